/* Makefile */
# Verilator build and run for the accelerator testbench

VERILATOR ?= verilator
TOP       ?= tb_accel_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_accel_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top: clock, reset, host tasks, tests
// Checking assertions and result reporting
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_accel_top;

  logic               clk;
  logic               rst_n;
  bus_pkg::reg_req_t  reg_req;
  bus_pkg::reg_rsp_t  reg_rsp;
  bus_pkg::obi_req_t  slv_req;
  bus_pkg::obi_resp_t slv_rsp;
  bus_pkg::obi_req_t  mst_req;
  bus_pkg::obi_resp_t mst_rsp;
  logic               irq;

  logic [31:0] rng = 32'd76683;
  logic [31:0] dly_rng = 32'd76683;
  logic [31:0] model_mem [256];
  logic [31:0] tgt_cnt;
  logic [31:0] tgt_addr;
  logic [31:0] tgt_data;

  // Check enables and expected values, driven with the stimulus
  logic        idle_chk;
  logic        rd_chk;
  logic        mem_chk;
  logic        job_chk;
  logic        irq_low_chk;
  logic        exp_err;
  logic [31:0] exp_rdata;
  logic [31:0] exp_mem;
  logic [31:0] exp_result;
  logic [31:0] exp_dst;
  logic [31:0] exp_jobs;
  int          err_cnt;
  int          test_base;
  int          test_cnt;
  int          tests_failed;

  accel_top uut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .reg_req_i    (reg_req),
    .reg_rsp_o    (reg_rsp),
    .slave_req_i  (slv_req),
    .slave_resp_o (slv_rsp),
    .master_req_o (mst_req),
    .master_resp_i(mst_rsp),
    .accel_int_o  (irq)
  );

  tb_obi_target target_i (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .req_i      (mst_req),
    .resp_o     (mst_rsp),
    .dly_i      (dly_rng[1:0]),
    .wr_cnt_o   (tgt_cnt),
    .last_addr_o(tgt_addr),
    .last_data_o(tgt_data)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Reference fold over the model memory, index wraps at 256
  function automatic logic [31:0] fold_expected(input logic [1:0] op, input logic [7:0] src,
                                                input logic [8:0] len);
    logic [31:0] acc;
    logic [31:0] w;
    acc = 32'h0;
    for (int k = 0; k < int'(len); k++) begin
      w = model_mem[8'(int'(src) + k)];
      case (op)
        2'd1: acc = acc ^ w;
        2'd2: acc = (w > acc) ? w : acc;
        default: acc = acc + w;
      endcase
    end
    return acc;
  endfunction

  task automatic value_error(input string sig, input logic [31:0] exp_val,
                             input logic [31:0] got_val);
    $display("FAILED t=%0t %s expected %h got %h", $time, sig, exp_val, got_val);
    err_cnt++;
  endtask

  task automatic abort_run(input string what);
    $display("[%0t] timeout while waiting for %s", $time, what);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic wait_reg_ready();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!reg_rsp.ready && n < 20);
    if (!reg_rsp.ready) abort_run("register bus ready");
    reg_req.valid <= 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] off, input logic [31:0] data,
                           input logic [3:0] strb);
    reg_req.addr  <= 32'(off);
    reg_req.write <= 1'b1;
    reg_req.wdata <= data;
    reg_req.wstrb <= strb;
    reg_req.valid <= 1'b1;
    wait_reg_ready();
  endtask

  task automatic reg_read(input logic [7:0] off, input logic [31:0] exp_val, input logic err);
    reg_req.addr  <= 32'(off);
    reg_req.write <= 1'b0;
    reg_req.wstrb <= 4'h0;
    reg_req.valid <= 1'b1;
    exp_rdata     <= exp_val;
    exp_err       <= err;
    rd_chk        <= 1'b1;
    wait_reg_ready();
    rd_chk <= 1'b0;
  endtask

  // One local memory access through the slave port
  task automatic mem_access(input logic we, input logic [7:0] idx, input logic [31:0] data,
                            input logic [3:0] be);
    int n;
    slv_req.req   <= 1'b1;
    slv_req.we    <= we;
    slv_req.be    <= be;
    slv_req.addr  <= {22'h0, idx, 2'b00};
    slv_req.wdata <= data;
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) model_mem[idx][8*b +: 8] = data[8*b +: 8];
      end
    end else begin
      exp_mem <= model_mem[idx];
      mem_chk <= 1'b1;
    end
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!slv_rsp.gnt && n < 400);
    if (!slv_rsp.gnt) abort_run("local memory grant");
    slv_req.req <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!slv_rsp.rvalid && n < 10);
    if (!slv_rsp.rvalid) abort_run("local memory rvalid");
    mem_chk <= 1'b0;
  endtask

  task automatic start_job(input logic [7:0] src, input logic [8:0] len,
                           input logic [31:0] dst, input logic [1:0] op);
    reg_write(accel_pkg::REG_SRC, 32'(src), 4'hF);
    reg_write(accel_pkg::REG_LEN, 32'(len), 4'hF);
    reg_write(accel_pkg::REG_DST, dst, 4'hF);
    reg_write(accel_pkg::REG_OP, 32'(op), 4'hF);
    exp_result = fold_expected(op, src, len);
    exp_dst    = dst;
    exp_jobs   = exp_jobs + 1;
    reg_write(accel_pkg::REG_CTRL, 32'h1, 4'h1);
  endtask

  // Wait for the interrupt, check result and target, then clear done
  task automatic finish_job();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!irq && n < 1000);
    if (!irq) abort_run("job interrupt");
    job_chk <= 1'b1;
    reg_read(accel_pkg::REG_RESULT, exp_result, 1'b0);
    job_chk <= 1'b0;
    reg_read(accel_pkg::REG_STATUS, 32'h2, 1'b0);
    reg_write(accel_pkg::REG_STATUS, 32'h2, 4'h1);
    irq_low_chk <= 1'b1;
    reg_read(accel_pkg::REG_STATUS, 32'h0, 1'b0);
    irq_low_chk <= 1'b0;
  endtask

  task automatic end_test(input string name);
    @(posedge clk);
    test_cnt++;
    if (err_cnt == test_base) begin
      $display("[%0t] test %0d %s: pass", $time, test_cnt, name);
    end else begin
      tests_failed++;
      $display("[%0t] test %0d %s: %0d check errors", $time, test_cnt, name,
               err_cnt - test_base);
    end
    test_base = err_cnt;
  endtask

  a_irq_low: assert property (@(posedge clk) disable iff (!rst_n)
    idle_chk || irq_low_chk |-> !irq)
    else value_error("accel_int_o", 32'h0, 32'($sampled(irq)));
  a_master_idle: assert property (@(posedge clk) disable iff (!rst_n)
    idle_chk |-> !mst_req.req)
    else value_error("master_req_o.req", 32'h0, 32'($sampled(mst_req.req)));
  a_master_be: assert property (@(posedge clk) disable iff (!rst_n)
    mst_req.req |-> mst_req.be == 4'hF)
    else value_error("master_req_o.be", 32'hF, 32'($sampled(mst_req.be)));
  a_reg_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    rd_chk && reg_rsp.ready |-> reg_rsp.rdata == exp_rdata)
    else value_error("reg_rsp_o.rdata", $sampled(exp_rdata), $sampled(reg_rsp.rdata));
  a_reg_error: assert property (@(posedge clk) disable iff (!rst_n)
    rd_chk && reg_rsp.ready |-> reg_rsp.error == exp_err)
    else value_error("reg_rsp_o.error", 32'($sampled(exp_err)), 32'($sampled(reg_rsp.error)));
  a_mem_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    mem_chk && slv_rsp.rvalid |-> slv_rsp.rdata == exp_mem)
    else value_error("slave_resp_o.rdata", $sampled(exp_mem), $sampled(slv_rsp.rdata));
  a_job_addr: assert property (@(posedge clk) disable iff (!rst_n)
    job_chk |-> tgt_addr == exp_dst)
    else value_error("master_req_o.addr", $sampled(exp_dst), $sampled(tgt_addr));
  a_job_data: assert property (@(posedge clk) disable iff (!rst_n)
    job_chk |-> tgt_data == exp_result)
    else value_error("master_req_o.wdata", $sampled(exp_result), $sampled(tgt_data));
  a_job_count: assert property (@(posedge clk) disable iff (!rst_n)
    job_chk |-> tgt_cnt == exp_jobs)
    else value_error("target write count", $sampled(exp_jobs), $sampled(tgt_cnt));

  always @(posedge clk) begin
    dly_rng <= xorshift(dly_rng);
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n       = 1'b0;
    reg_req     = '0;
    slv_req     = '0;
    idle_chk    = 1'b0;
    rd_chk      = 1'b0;
    mem_chk     = 1'b0;
    job_chk     = 1'b0;
    irq_low_chk = 1'b0;
    exp_jobs    = 32'h0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    idle_chk <= 1'b1;
    reg_write(accel_pkg::REG_SRC, 32'h0000_00A5, 4'hF);
    reg_read(accel_pkg::REG_SRC, 32'h0000_00A5, 1'b0);
    reg_write(accel_pkg::REG_LEN, 32'h0000_0100, 4'hF);
    reg_read(accel_pkg::REG_LEN, 32'h0000_0100, 1'b0);
    reg_write(accel_pkg::REG_DST, 32'h8000_1234, 4'hF);
    reg_read(accel_pkg::REG_DST, 32'h8000_1234, 1'b0);
    reg_write(accel_pkg::REG_OP, 32'h2, 4'hF);
    reg_read(accel_pkg::REG_OP, 32'h2, 1'b0);
    reg_write(accel_pkg::REG_IRQ_EN, 32'h1, 4'hF);
    reg_read(accel_pkg::REG_IRQ_EN, 32'h1, 1'b0);
    reg_read(8'h20, 32'h0, 1'b1);
    idle_chk <= 1'b0;
    end_test("reset and registers");

    for (int i = 0; i < 256; i++) begin
      mem_access(1'b1, 8'(i), next_rand(), 4'hF);
    end
    mem_access(1'b1, 8'h10, 32'hA5A5_A5A5, 4'b0101);
    mem_access(1'b1, 8'h11, 32'h1234_5678, 4'b1000);
    mem_access(1'b0, 8'h10, 32'h0, 4'h0);
    mem_access(1'b0, 8'h11, 32'h0, 4'h0);
    mem_access(1'b0, 8'hFF, 32'h0, 4'h0);
    end_test("local memory access");

    start_job(8'd3, 9'd40, 32'h8000_0100, 2'd0);
    finish_job();
    end_test("add job");

    // Ranges past index 255, op code 3 and an empty job
    start_job(8'd240, 9'd32, 32'h8000_0200, 2'd1);
    finish_job();
    start_job(8'd250, 9'd20, 32'h8000_0300, 2'd2);
    finish_job();
    start_job(8'd128, 9'd256, 32'h8000_0400, 2'd3);
    finish_job();
    start_job(8'd7, 9'd0, 32'h8000_0500, 2'd0);
    finish_job();
    end_test("xor, max and zero length");

    start_job(8'd0, 9'd200, 32'h8000_0600, 2'd0);
    for (int i = 0; i < 8; i++) begin
      mem_access(1'b0, 8'(i * 29 + 5), 32'h0, 4'h0);
    end
    finish_job();
    end_test("host access while busy");

    start_job(8'd16, 9'd64, 32'h8000_0700, 2'd1);
    reg_write(accel_pkg::REG_CTRL, 32'h1, 4'h1);
    reg_write(accel_pkg::REG_CTRL, 32'h1, 4'h1);
    finish_job();
    end_test("start while busy");

    $display("tests run %0d, tests failing %0d, check errors %0d",
             test_cnt, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* dv/tb_obi_target.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// External memory model for the engine's writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_obi_target (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  bus_pkg::obi_req_t  req_i,
  output bus_pkg::obi_resp_t resp_o,
  input  logic [1:0]         dly_i,
  output logic [31:0]        wr_cnt_o,
  output logic [31:0]        last_addr_o,
  output logic [31:0]        last_data_o
);

  logic [1:0] wait_q;
  logic       gnt;
  logic       rvalid_q;

  // Grant once the drawn delay has run out
  assign gnt = req_i.req & (wait_q == 2'd0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_q      <= '0;
      rvalid_q    <= 1'b0;
      wr_cnt_o    <= '0;
      last_addr_o <= '0;
      last_data_o <= '0;
    end else begin
      rvalid_q <= gnt;
      // Fresh delay drawn while idle
      if (!req_i.req || gnt) begin
        wait_q <= dly_i;
      end else begin
        wait_q <= wait_q - 1'b1;
      end
      if (gnt && req_i.we) begin
        wr_cnt_o    <= wr_cnt_o + 1'b1;
        last_addr_o <= req_i.addr;
        last_data_o <= req_i.wdata;
      end
    end
  end

  assign resp_o.gnt    = gnt;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = '0;

endmodule

/* logic/accel_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Accelerator register map, opcodes, memory depth
// Job configuration and engine status structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package accel_pkg;

  // Local memory
  localparam int unsigned CMEM_DEPTH = 256;
  localparam int unsigned CMEM_AW    = 8;

  // Register offsets, decoded on the low address byte
  localparam int unsigned REG_OFF_W = 8;

  localparam logic [REG_OFF_W-1:0] REG_CTRL   = 8'h00;
  localparam logic [REG_OFF_W-1:0] REG_SRC    = 8'h04;
  localparam logic [REG_OFF_W-1:0] REG_LEN    = 8'h08;
  localparam logic [REG_OFF_W-1:0] REG_DST    = 8'h0C;
  localparam logic [REG_OFF_W-1:0] REG_OP     = 8'h10;
  localparam logic [REG_OFF_W-1:0] REG_STATUS = 8'h14;
  localparam logic [REG_OFF_W-1:0] REG_IRQ_EN = 8'h18;
  localparam logic [REG_OFF_W-1:0] REG_RESULT = 8'h1C;

  // Code 3 folds as add
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_XOR = 2'd1,
    OP_MAX = 2'd2
  } op_e;

  typedef struct packed {
    logic [CMEM_AW-1:0]        src;
    logic [CMEM_AW:0]          len;
    logic [bus_pkg::ADDR_W-1:0] dst;
    op_e                       op;
  } job_cfg_t;

  // done is a single-cycle pulse
  typedef struct packed {
    logic                      busy;
    logic                      done;
    logic [bus_pkg::DATA_W-1:0] result;
  } engine_stat_t;

endpackage

/* logic/accel_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register block: job setup, start, status, irq
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module accel_regs (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  bus_pkg::reg_req_t       reg_req_i,
  output bus_pkg::reg_rsp_t       reg_rsp_o,
  input  accel_pkg::engine_stat_t stat_i,
  output accel_pkg::job_cfg_t     cfg_o,
  output logic                    start_o,
  output logic                    irq_o
);

  logic [accel_pkg::REG_OFF_W-1:0] reg_off;
  logic [bus_pkg::DATA_W-1:0]      rd_val;
  logic [bus_pkg::DATA_W-1:0]      wr_val;
  logic                            hit;
  logic                            wr_en;
  logic                            start_req;

  logic [accel_pkg::CMEM_AW-1:0]   src_q;
  logic [accel_pkg::CMEM_AW:0]     len_q;
  logic [bus_pkg::ADDR_W-1:0]      dst_q;
  logic [1:0]                      op_q;
  logic                            irq_en_q;
  logic                            done_q;
  logic [bus_pkg::DATA_W-1:0]      result_q;
  logic                            start_q;

  // Byte-lane merge of write data into the current value
  function automatic logic [bus_pkg::DATA_W-1:0] strb_merge(
    input logic [bus_pkg::DATA_W-1:0]   old_val,
    input logic [bus_pkg::DATA_W-1:0]   new_val,
    input logic [bus_pkg::DATA_W/8-1:0] strb
  );
    logic [bus_pkg::DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < bus_pkg::DATA_W / 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign reg_off = reg_req_i.addr[accel_pkg::REG_OFF_W-1:0];

  always_comb begin
    rd_val = '0;
    hit    = 1'b1;
    case (reg_off)
      accel_pkg::REG_CTRL:   rd_val = '0;
      accel_pkg::REG_SRC:    rd_val[accel_pkg::CMEM_AW-1:0] = src_q;
      accel_pkg::REG_LEN:    rd_val[accel_pkg::CMEM_AW:0] = len_q;
      accel_pkg::REG_DST:    rd_val = dst_q;
      accel_pkg::REG_OP:     rd_val[1:0] = op_q;
      accel_pkg::REG_STATUS: rd_val[1:0] = {done_q, stat_i.busy};
      accel_pkg::REG_IRQ_EN: rd_val[0] = irq_en_q;
      accel_pkg::REG_RESULT: rd_val = result_q;
      default:               hit = 1'b0;
    endcase
  end

  // Every access completes in the cycle it is presented
  assign reg_rsp_o.ready = reg_req_i.valid;
  assign reg_rsp_o.error = reg_req_i.valid & ~hit;
  assign reg_rsp_o.rdata = rd_val;

  assign wr_en  = reg_req_i.valid & reg_req_i.write & hit;
  assign wr_val = strb_merge(rd_val, reg_req_i.wdata, reg_req_i.wstrb);

  // A start already in flight also blocks a second one
  assign start_req = wr_en & (reg_off == accel_pkg::REG_CTRL) & reg_req_i.wstrb[0]
                   & reg_req_i.wdata[0] & ~stat_i.busy & ~start_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q    <= '0;
      len_q    <= '0;
      dst_q    <= '0;
      op_q     <= '0;
      irq_en_q <= 1'b0;
      done_q   <= 1'b0;
      result_q <= '0;
      start_q  <= 1'b0;
    end else begin
      start_q <= start_req;
      if (wr_en) begin
        case (reg_off)
          accel_pkg::REG_SRC:    src_q <= wr_val[accel_pkg::CMEM_AW-1:0];
          accel_pkg::REG_LEN:    len_q <= wr_val[accel_pkg::CMEM_AW:0];
          accel_pkg::REG_DST:    dst_q <= wr_val;
          accel_pkg::REG_OP:     op_q <= wr_val[1:0];
          accel_pkg::REG_IRQ_EN: irq_en_q <= wr_val[0];
          accel_pkg::REG_STATUS: begin
            if (reg_req_i.wstrb[0] && reg_req_i.wdata[1]) begin
              done_q <= 1'b0;
            end
          end
          default: ;
        endcase
      end
      // New completion wins over a clear in the same cycle
      if (stat_i.done) begin
        done_q   <= 1'b1;
        result_q <= stat_i.result;
      end
    end
  end

  assign cfg_o.src = src_q;
  assign cfg_o.len = len_q;
  assign cfg_o.dst = dst_q;
  assign cfg_o.op  = accel_pkg::op_e'(op_q);
  assign start_o   = start_q;
  assign irq_o     = done_q & irq_en_q;

  a_ready_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    reg_rsp_o.ready |-> reg_req_i.valid
  );

endmodule

/* logic/accel_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Accelerator top: registers, memory, engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module accel_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  bus_pkg::reg_req_t  reg_req_i,
  output bus_pkg::reg_rsp_t  reg_rsp_o,
  input  bus_pkg::obi_req_t  slave_req_i,
  output bus_pkg::obi_resp_t slave_resp_o,
  output bus_pkg::obi_req_t  master_req_o,
  input  bus_pkg::obi_resp_t master_resp_i,
  output logic               accel_int_o
);

  accel_pkg::job_cfg_t           job_cfg;
  accel_pkg::engine_stat_t       eng_stat;
  logic                          job_start;

  // Engine side of the local memory
  logic                          cmem_rd_en;
  logic [accel_pkg::CMEM_AW-1:0] cmem_rd_idx;
  logic [bus_pkg::DATA_W-1:0]    cmem_rd_data;

  accel_regs accel_regs_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i,
    .reg_rsp_o,
    .stat_i   (eng_stat),
    .cfg_o    (job_cfg),
    .start_o  (job_start),
    .irq_o    (accel_int_o)
  );

  cmem_bank cmem_bank_i (
    .clk_i,
    .rst_n_i,
    .slave_req_i,
    .slave_resp_o,
    .rd_en_i  (cmem_rd_en),
    .rd_idx_i (cmem_rd_idx),
    .rd_data_o(cmem_rd_data)
  );

  reduce_engine reduce_engine_i (
    .clk_i,
    .rst_n_i,
    .cfg_i    (job_cfg),
    .start_i  (job_start),
    .rd_en_o  (cmem_rd_en),
    .rd_idx_o (cmem_rd_idx),
    .rd_data_i(cmem_rd_data),
    .master_req_o,
    .master_resp_i,
    .stat_o   (eng_stat)
  );

endmodule

/* logic/bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths, register-bus and memory-bus structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Register bus, valid/ready handshake
  typedef struct packed {
    logic [ADDR_W-1:0]   addr;
    logic                write;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic                valid;
  } reg_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              error;
    logic              ready;
  } reg_rsp_t;

  // Memory bus, req/gnt then rvalid
  typedef struct packed {
    logic                req;
    logic                we;
    logic [DATA_W/8-1:0] be;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
  } obi_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } obi_resp_t;

endpackage

/* logic/cmem_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port local memory, engine read priority
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module cmem_bank (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  bus_pkg::obi_req_t             slave_req_i,
  output bus_pkg::obi_resp_t            slave_resp_o,
  input  logic                          rd_en_i,
  input  logic [accel_pkg::CMEM_AW-1:0] rd_idx_i,
  output logic [bus_pkg::DATA_W-1:0]    rd_data_o
);

  logic [bus_pkg::DATA_W-1:0]    mem [accel_pkg::CMEM_DEPTH];
  logic [bus_pkg::DATA_W-1:0]    data_q;
  logic [accel_pkg::CMEM_AW-1:0] idx;
  logic                          host_gnt;
  logic                          rvalid_q;

  // Host waits whenever the engine owns the port
  assign host_gnt = slave_req_i.req & ~rd_en_i;
  assign idx      = rd_en_i ? rd_idx_i : slave_req_i.addr[accel_pkg::CMEM_AW+1:2];

  always_ff @(posedge clk_i) begin
    if (rd_en_i || (host_gnt && !slave_req_i.we)) begin
      data_q <= mem[idx];
    end else if (host_gnt) begin
      for (int b = 0; b < bus_pkg::DATA_W / 8; b++) begin
        if (slave_req_i.be[b]) begin
          mem[idx][8*b +: 8] <= slave_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= host_gnt;
    end
  end

  // One read register serves both sides, one access per cycle
  assign rd_data_o           = data_q;
  assign slave_resp_o.gnt    = host_gnt;
  assign slave_resp_o.rvalid = rvalid_q;
  assign slave_resp_o.rdata  = data_q;

  a_no_gnt_on_engine_rd: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    slave_resp_o.gnt |-> !rd_en_i
  );

endmodule

/* logic/reduce_engine.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reduction engine: memory stream, fold, bus write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module reduce_engine (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  accel_pkg::job_cfg_t           cfg_i,
  input  logic                          start_i,
  output logic                          rd_en_o,
  output logic [accel_pkg::CMEM_AW-1:0] rd_idx_o,
  input  logic [bus_pkg::DATA_W-1:0]    rd_data_i,
  output bus_pkg::obi_req_t             master_req_o,
  input  bus_pkg::obi_resp_t            master_resp_i,
  output accel_pkg::engine_stat_t       stat_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,
    ST_DRAIN,
    ST_WRITE,
    ST_WAIT
  } state_e;

  state_e                        state_q;
  logic [accel_pkg::CMEM_AW-1:0] idx_q;
  logic [accel_pkg::CMEM_AW:0]   cnt_q;
  logic [bus_pkg::DATA_W-1:0]    acc_q;
  logic [bus_pkg::ADDR_W-1:0]    dst_q;
  accel_pkg::op_e                op_q;
  logic                          data_vld_q;
  logic                          rsp_done;

  function automatic logic [bus_pkg::DATA_W-1:0] fold(
    input accel_pkg::op_e             op,
    input logic [bus_pkg::DATA_W-1:0] acc,
    input logic [bus_pkg::DATA_W-1:0] din
  );
    case (op)
      accel_pkg::OP_XOR: return acc ^ din;
      accel_pkg::OP_MAX: return (din > acc) ? din : acc;
      default:           return acc + din;
    endcase
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      idx_q      <= '0;
      cnt_q      <= '0;
      acc_q      <= '0;
      dst_q      <= '0;
      op_q       <= accel_pkg::OP_ADD;
      data_vld_q <= 1'b0;
    end else begin
      // Memory data lands one cycle after each read
      data_vld_q <= rd_en_o;
      if (data_vld_q) begin
        acc_q <= fold(op_q, acc_q, rd_data_i);
      end

      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            idx_q   <= cfg_i.src;
            cnt_q   <= cfg_i.len;
            dst_q   <= cfg_i.dst;
            op_q    <= cfg_i.op;
            acc_q   <= '0;
            state_q <= (cfg_i.len == '0) ? ST_WRITE : ST_READ;
          end
        end
        ST_READ: begin
          // Index wraps at the top of memory
          idx_q <= idx_q + 1'b1;
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == 1) begin
            state_q <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          state_q <= ST_WRITE;
        end
        ST_WRITE: begin
          if (master_resp_i.gnt) begin
            state_q <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (master_resp_i.rvalid) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign rd_en_o  = (state_q == ST_READ);
  assign rd_idx_o = idx_q;

  assign master_req_o.req   = (state_q == ST_WRITE);
  assign master_req_o.we    = 1'b1;
  assign master_req_o.be    = '1;
  assign master_req_o.addr  = dst_q;
  assign master_req_o.wdata = acc_q;

  assign rsp_done = (state_q == ST_WAIT) & master_resp_i.rvalid;

  assign stat_o.busy   = (state_q != ST_IDLE);
  assign stat_o.done   = rsp_done;
  assign stat_o.result = acc_q;

  a_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    master_req_o.req && !master_resp_i.gnt |=> master_req_o.req && $stable(master_req_o)
  );

  // The target may only answer a write it has granted
  a_rvalid_outstanding: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    master_resp_i.rvalid |-> state_q == ST_WAIT
  );

endmodule

/* tb.f */
logic/bus_pkg.sv
logic/accel_pkg.sv
logic/accel_regs.sv
logic/cmem_bank.sv
logic/reduce_engine.sv
logic/accel_top.sv
dv/tb_obi_target.sv
dv/tb_accel_top.sv
